// ==== dv/lsu_slice_tb.sv ====
// lsu_slice_tb drives the load/store slice from a stimulus file and checks every writeback
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_slice_tb;

	localparam int BUSY_LIMIT = 50;
	localparam int WB_LIMIT = 50;
	// a memory access takes the fixed memory latency plus issue, launch and writeback
	localparam int MEM_OP_LAT = `LSU_MEM_LAT + 3;
	localparam int FENCE_LAT = 3;

	logic              CLK;
	logic              rst;
	lsu_pkg::lsu_cmd_t cmd;
	logic              cmd_valid;
	logic              cmd_busy;
	logic              flush;
	logic              wb_valid;
	lsu_pkg::wb_t      wb;

	lsu_slice_top uut (
		.CLK       (CLK),
		.rst       (rst),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_busy  (cmd_busy),
		.flush     (flush),
		.wb_valid  (wb_valid),
		.wb        (wb)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// ########################################
	// checking
	// ########################################

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	function automatic lsu_pkg::lsu_cmd_t make_cmd(input logic [3:0] op,
		input lsu_pkg::funct3_t f3, input lsu_pkg::rd_tag_t rd,
		input lsu_pkg::xlen_t base, input lsu_pkg::imm12_t offset);
		lsu_pkg::lsu_cmd_t c;
		c = '0;
		c.is_load = (op == 4'd0) || (op == 4'd4);
		c.is_store = (op == 4'd1);
		c.is_fence = (op == 4'd2);
		c.is_fence_i = (op == 4'd3);
		c.funct3 = f3;
		c.rd = rd;
		c.base = base;
		c.offset = offset;
		return c;
	endfunction

	// ########################################
	// command sequences
	// ########################################

	// called right after a falling edge, so cmd_busy is already settled
	task automatic wait_idle();
		int n;
		n = 0;
		while (cmd_busy !== 1'b0) begin
			if (n >= BUSY_LIMIT) begin
				$display("timeout: cmd_busy stayed high for %0d cycles", BUSY_LIMIT);
				stop_run();
			end
			@(negedge CLK);
			n++;
		end
	endtask

	// n is the number of rising edges since cmd_valid was raised
	task automatic run_command(input lsu_pkg::lsu_cmd_t c, input lsu_pkg::xlen_t exp_res,
		input lsu_pkg::rd_tag_t exp_tag, input int exp_lat);
		int n;
		wait_idle();
		@(posedge CLK);
		#10;
		cmd = c;
		cmd_valid = 1'b1;
		@(posedge CLK);
		#10;
		cmd_valid = 1'b0;
		n = 1;
		@(negedge CLK);
		while (wb_valid !== 1'b1) begin
			// the buffer must hold off new commands until the writeback
			check_value("cmd_busy", cmd_busy, 1);
			if (n >= WB_LIMIT) begin
				$display("timeout: no writeback for tag %h within %0d cycles", exp_tag, WB_LIMIT);
				stop_run();
			end
			@(negedge CLK);
			n++;
		end
		check_value("cmd_busy", cmd_busy, 1);
		check_value("wb.result", wb.result, exp_res);
		check_value("wb.rd", wb.rd, exp_tag);
		check_value("writeback latency", n, exp_lat);
		@(negedge CLK);
		check_value("wb_valid", wb_valid, 0);
		check_value("cmd_busy", cmd_busy, 0);
	endtask

	// the load is dropped by a flush in cycle flush_at after acceptance
	task automatic run_flushed(input lsu_pkg::lsu_cmd_t c, input int flush_at);
		int n;
		if (flush_at < 1 || flush_at >= MEM_OP_LAT) begin
			$display("stimulus error: flush cycle %0d is outside the load's lifetime", flush_at);
			stop_run();
		end
		wait_idle();
		@(posedge CLK);
		#10;
		cmd = c;
		cmd_valid = 1'b1;
		// watch long enough for a dropped response to have come and gone
		for (n = 1; n <= flush_at + MEM_OP_LAT; n++) begin
			@(posedge CLK);
			#10;
			cmd_valid = 1'b0;
			flush = (n == flush_at);
			@(negedge CLK);
			check_value("wb_valid after flush", wb_valid, 0);
			if (n > flush_at) check_value("cmd_busy after flush", cmd_busy, 0);
		end
	endtask

	// ########################################
	// main sequence
	// ########################################

	initial begin
		int                fd;
		int                code;
		int                fields;
		int                commands;
		string             line;
		logic [3:0]        op;
		lsu_pkg::funct3_t  f3;
		lsu_pkg::rd_tag_t  rd_v;
		lsu_pkg::xlen_t    base_v;
		lsu_pkg::imm12_t   off_v;
		lsu_pkg::xlen_t    res_v;
		lsu_pkg::rd_tag_t  tag_v;
		lsu_pkg::lsu_cmd_t c;

		cmd = '0;
		cmd_valid = 1'b0;
		flush = 1'b0;
		rst = 1'b1;
		commands = 0;

		repeat (5) @(posedge CLK);
		#10;
		rst = 1'b0;

		// nothing may be busy or written back before the first command
		repeat (3) begin
			@(negedge CLK);
			check_value("wb_valid after reset", wb_valid, 0);
			check_value("cmd_busy after reset", cmd_busy, 0);
		end

		fd = $fopen("dv/lsu_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/lsu_stim.txt");
			stop_run();
		end

		code = $fgets(line, fd);
		while (code != 0) begin
			if (line.len() > 2 && line[0] != "#") begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h",
					op, f3, rd_v, base_v, off_v, res_v, tag_v);
				if (fields != 7) begin
					$display("stimulus line could not be read: %s", line);
					stop_run();
				end
				c = make_cmd(op, f3, rd_v, base_v, off_v);
				case (op)
					4'd0, 4'd1: run_command(c, res_v, tag_v, MEM_OP_LAT);
					4'd2, 4'd3: run_command(c, res_v, tag_v, FENCE_LAT);
					4'd4: run_flushed(c, int'(res_v));
					default: begin
						$display("stimulus line has an unknown operation code %h", op);
						stop_run();
					end
				endcase
				commands++;
			end
			code = $fgets(line, fd);
		end
		$fclose(fd);

		if (commands == 0) begin
			$display("the stimulus file holds no commands");
			stop_run();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== dv/lsu_stim.txt ====
# columns, all hex: op funct3 rd base offset result tag
# op 0 load, 1 store (base carries the data), 2 fence, 3 fence.i, 4 load flushed in cycle <result>
# store and load back for every width, signed and unsigned
1 3 01 fedcba9876543210 100 0 01
0 3 02 0000000000000080 080 fedcba9876543210 02
1 2 03 1122334489abcdef 108 0 03
0 2 04 0000000000000108 000 ffffffff89abcdef 04
0 6 05 0000000000000100 008 0000000089abcdef 05
1 2 06 000000007654abcd 10c 0 06
0 2 07 0000000000000110 ffc 000000007654abcd 07
1 1 08 0000000000008001 110 0 08
0 1 09 0000000000000200 f10 ffffffffffff8001 09
0 5 0a 0000000000000110 000 0000000000008001 0a
1 1 0b 0000000000001234 112 0 0b
0 1 0c 0000000000000112 000 0000000000001234 0c
1 0 0d 00000000000000f0 118 0 0d
0 0 0e 0000000000000118 000 fffffffffffffff0 0e
0 4 0f 0000000000000118 000 00000000000000f0 0f
1 0 10 000000000000007f 119 0 10
0 0 11 0000000000000119 000 000000000000007f 11
1 3 12 0a0b0c0d0e0f1011 7f8 0 12
0 3 13 10000000000007f0 008 0a0b0c0d0e0f1011 13
# narrow stores at byte offsets merged into one doubleword
1 3 20 0123456789abcdef 180 0 20
1 0 21 00000000000000aa 183 0 21
1 1 22 00000000000055bb 186 0 22
1 0 23 0000000000000011 185 0 23
0 3 24 0000000000000180 000 55bb1167aaabcdef 24
0 1 25 0000000000000180 002 ffffffffffffaaab 25
0 4 26 0000000000000186 000 00000000000000bb 26
0 6 27 0000000000000184 000 0000000055bb1167 27
0 2 28 0000000000000180 000 ffffffffaaabcdef 28
1 2 29 00000000deadbeef 184 0 29
0 3 2a 0000000000000100 080 deadbeefaaabcdef 2a
# fences write back zero with their own tag
2 0 30 0000000000001234 7ff 0 30
3 0 31 ffffffffffffffff 001 0 31
# loads dropped by a flush, each followed by a normal command
4 3 40 0000000000000180 000 1 40
0 3 41 0000000000000180 000 deadbeefaaabcdef 41
4 3 42 0000000000000100 000 2 42
0 0 43 0000000000000118 000 fffffffffffffff0 43
4 2 44 0000000000000108 000 3 44
0 5 45 0000000000000110 000 0000000000008001 45
4 1 46 0000000000000110 000 4 46
1 3 47 5a5a5a5a5a5a5a5a 1f8 0 47
0 3 48 00000000000001f8 000 5a5a5a5a5a5a5a5a 48
4 6 49 00000000000001f8 000 5 49
2 0 4a 0000000000000000 000 0 4a
# back to back commands with tags that use the rename bits
1 3 7f 8000000000000001 1c0 0 7f
0 3 40 00000000000001c0 000 8000000000000001 40
0 0 65 00000000000001c0 007 ffffffffffffff80 65
3 0 5a 0000000000000000 000 0 5a
0 4 33 00000000000001c0 000 0000000000000001 33

// ==== include/lsu_settings.svh ====
// load/store slice settings for data and address widths, tag width, memory size and latency
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ########################################
// datapath
// ########################################

// width of a register operand and of a memory doubleword
`define LSU_XLEN 64

// address bits that the data memory decodes
`define LSU_AW 16

// rename bits appended to the 5-bit architectural register index
`define LSU_RB 2

// ########################################
// data memory
// ########################################

// number of doublewords in the data memory
`define LSU_MEM_DEPTH 512

// cycles from an accepted request to its response with a minimum of 1
`define LSU_MEM_LAT 3

`endif

// ==== project.f ====
+incdir+include
src/lsu_pkg.sv
src/lsu_issue.sv
src/lsu.sv
src/lsu_dmem.sv
src/lsu_slice_top.sv
dv/lsu_slice_tb.sv

// ==== src/lsu.sv ====
// lsu issues data memory requests, tracks the access and formats the writeback result
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu (
	input  logic                   CLK,
	input  logic                   rst,
	input  lsu_pkg::lsu_exeparam_t exeparam,
	input  logic                   exeparam_valid,
	output logic                   exeparam_ready,
	output logic                   mst_req_valid,
	input  logic                   mst_req_ready,
	output lsu_pkg::mem_req_t      req,
	input  lsu_pkg::xlen_t         rdata,
	input  logic                   slv_rsp_valid,
	input  logic                   flush,
	output logic                   wb_valid,
	output lsu_pkg::wb_t           wb
);

	logic             is_fence_any;
	logic             pending;
	logic             pending_set;
	logic             pending_clr;
	logic             wb_set;
	logic             wb_clr;
	logic             dropped;
	logic             fun_b;
	logic             fun_h;
	logic             fun_w;
	logic             fun_d;
	logic             is_usi;
	lsu_pkg::rd_tag_t rd_q;
	lsu_pkg::xlen_t   result;

	assign is_fence_any = exeparam.fence | exeparam.fence_i;

	// ########################################
	// request
	// ########################################

	// fences never reach the memory
	assign mst_req_valid = exeparam_valid & ~is_fence_any & ~flush;

	always_comb begin
		req.addr = exeparam.op1[`LSU_AW-1:0];
		req.wdata = exeparam.op2;
		req.wen = exeparam.sb | exeparam.sh | exeparam.sw | exeparam.sd;
		req.wstrb = ({8{exeparam.sb}} & 8'h01)
			| ({8{exeparam.sh}} & 8'h03)
			| ({8{exeparam.sw}} & 8'h0f)
			| ({8{exeparam.sd}} & 8'hff);
	end

	assign exeparam_ready = ~mst_req_valid & ~pending & mst_req_ready;

	// width and tag are kept for the response while stores and fences leave all widths clear
	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			fun_b <= exeparam.lb | exeparam.lbu;
			fun_h <= exeparam.lh | exeparam.lhu;
			fun_w <= exeparam.lw | exeparam.lwu;
			fun_d <= exeparam.ld;
			is_usi <= exeparam.lbu | exeparam.lhu | exeparam.lwu;
			rd_q <= exeparam.rd;
		end
	end

	// ########################################
	// pending access and writeback
	// ########################################

	assign pending_set = mst_req_valid & ~flush;
	assign pending_clr = (slv_rsp_valid & ~mst_req_valid) | flush;

	assign wb_set = ((slv_rsp_valid & pending) | (is_fence_any & exeparam_valid)) & ~flush;
	assign wb_clr = wb_valid | flush;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pending <= 1'b0;
			wb_valid <= 1'b0;
			dropped <= 1'b0;
		end else begin
			if (pending_set) pending <= 1'b1;
			else if (pending_clr) pending <= 1'b0;

			if (wb_set) wb_valid <= 1'b1;
			else if (wb_clr) wb_valid <= 1'b0;

			// a flushed access still has its response on the way unless it arrives now
			if (flush & pending & ~slv_rsp_valid) dropped <= 1'b1;
			else if (slv_rsp_valid) dropped <= 1'b0;
		end
	end

	// rdata arrives right-justified, so only the extension differs per width
	always_comb begin
		result = '0;
		if (fun_b) begin
			result = is_usi ? {{(`LSU_XLEN-8){1'b0}}, rdata[7:0]} :
				{{(`LSU_XLEN-8){rdata[7]}}, rdata[7:0]};
		end else if (fun_h) begin
			result = is_usi ? {{(`LSU_XLEN-16){1'b0}}, rdata[15:0]} :
				{{(`LSU_XLEN-16){rdata[15]}}, rdata[15:0]};
		end else if (fun_w) begin
			result = is_usi ? {{(`LSU_XLEN-32){1'b0}}, rdata[31:0]} :
				{{(`LSU_XLEN-32){rdata[31]}}, rdata[31:0]};
		end else if (fun_d) begin
			result = rdata;
		end
	end

	always_comb begin
		wb.rd = rd_q;
		wb.result = result;
	end

	a_wb_single: assert property (@(posedge CLK) disable iff (rst)
		wb_valid |=> !wb_valid);

	a_rsp_owned: assert property (@(posedge CLK) disable iff (rst)
		slv_rsp_valid |-> (pending || dropped));

endmodule

// ==== src/lsu_dmem.sv ====
// lsu_dmem is a byte-addressed data memory with lane alignment and a fixed response latency
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_dmem (
	input  logic               CLK,
	input  logic               rst,
	input  logic               mst_req_valid,
	output logic               mst_req_ready,
	input  lsu_pkg::mem_req_t  req,
	output logic               slv_rsp_valid,
	output lsu_pkg::xlen_t     rdata
);

	localparam int LAT = `LSU_MEM_LAT;
	localparam int DEPTH = `LSU_MEM_DEPTH;
	localparam int NB = `LSU_XLEN / 8;
	localparam int OFF_W = $clog2(NB);
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(LAT + 1);

	lsu_pkg::xlen_t    mem [DEPTH];
	logic [CNT_W-1:0]  cnt;
	logic              accept;
	logic [IDX_W-1:0]  idx;
	logic [OFF_W-1:0]  off;
	logic [2*NB-1:0]   strb_wide;
	lsu_pkg::strb_t    lane_strb;
	lsu_pkg::xlen_t    lane_data;

	assign accept = mst_req_valid & mst_req_ready;

	// ########################################
	// lane alignment
	// ########################################

	// address bits above the byte offset select the doubleword
	assign idx = req.addr[IDX_W+OFF_W-1:OFF_W];
	assign off = req.addr[OFF_W-1:0];

	// the upper half catches strobes pushed past the doubleword
	assign strb_wide = {{NB{1'b0}}, req.wstrb} << off;
	assign lane_strb = strb_wide[NB-1:0];
	assign lane_data = req.wdata << {off, 3'b000};

	// ########################################
	// response timing
	// ########################################

	// ready stays low from the cycle after a request through its response cycle
	assign mst_req_ready = (cnt == '0);
	assign slv_rsp_valid = (cnt == CNT_W'(1));

	always_ff @(posedge CLK) begin
		if (rst) begin
			cnt <= '0;
		end else if (accept) begin
			cnt <= CNT_W'(LAT);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// ########################################
	// storage
	// ########################################

	always_ff @(posedge CLK) begin
		if (accept) begin
			if (req.wen) begin
				for (int b = 0; b < NB; b++) begin
					if (lane_strb[b]) mem[idx][b*8 +: 8] <= lane_data[b*8 +: 8];
				end
			end else begin
				// read data is held right-justified until the next read
				rdata <= mem[idx] >> {off, 3'b000};
			end
		end
	end

	// a store keeps its strobes inside the addressed doubleword
	a_no_dword_cross: assert property (@(posedge CLK) disable iff (rst)
		accept && req.wen |-> strb_wide[2*NB-1:NB] == '0);

endmodule

// ==== src/lsu_issue.sv ====
// lsu_issue is a one-entry command buffer that forms the address, decodes funct3 and launches lsu
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_issue (
	input  logic                   CLK,
	input  logic                   rst,
	input  lsu_pkg::lsu_cmd_t      cmd,
	input  logic                   cmd_valid,
	output logic                   cmd_busy,
	input  logic                   flush,
	input  logic                   exeparam_ready,
	input  logic                   wb_valid,
	output lsu_pkg::lsu_exeparam_t exeparam,
	output logic                   exeparam_valid
);

	lsu_pkg::issue_state_t  state;
	lsu_pkg::lsu_exeparam_t param_next;
	lsu_pkg::xlen_t         offset_sext;
	logic                   accept;
	logic                   launch;
	logic                   funct3_legal;

	// a flush in the same cycle as a new command drops that command too
	assign accept = (state == lsu_pkg::EMPTY) & cmd_valid & ~flush;
	assign launch = (state == lsu_pkg::HELD) & exeparam_ready & ~flush;
	assign cmd_busy = (state != lsu_pkg::EMPTY);

	assign offset_sext = {{(`LSU_XLEN-12){cmd.offset[11]}}, cmd.offset};

	// loads use every funct3 but 111 and stores only the four widths without bit 2
	assign funct3_legal = cmd.is_load ? (cmd.funct3 != 3'b111) :
		cmd.is_store ? ~cmd.funct3[2] : 1'b1;

	// ########################################
	// decode
	// ########################################

	always_comb begin
		param_next = '0;
		param_next.fence = cmd.is_fence;
		param_next.fence_i = cmd.is_fence_i;
		param_next.rd = cmd.rd;
		if (cmd.is_store) begin
			// the store address comes from the offset alone because the base field holds the data
			param_next.op1 = offset_sext;
			param_next.op2 = cmd.base;
			case (cmd.funct3)
				3'b000: param_next.sb = 1'b1;
				3'b001: param_next.sh = 1'b1;
				3'b010: param_next.sw = 1'b1;
				3'b011: param_next.sd = 1'b1;
				default: param_next.sd = 1'b0;
			endcase
		end else begin
			param_next.op1 = cmd.base + offset_sext;
			if (cmd.is_load) begin
				case (cmd.funct3)
					3'b000: param_next.lb = 1'b1;
					3'b001: param_next.lh = 1'b1;
					3'b010: param_next.lw = 1'b1;
					3'b011: param_next.ld = 1'b1;
					3'b100: param_next.lbu = 1'b1;
					3'b101: param_next.lhu = 1'b1;
					3'b110: param_next.lwu = 1'b1;
					default: param_next.ld = 1'b0;
				endcase
			end
		end
	end

	// ########################################
	// state machine
	// ########################################

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= lsu_pkg::EMPTY;
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= launch;
			case (state)
				lsu_pkg::EMPTY: if (accept) state <= lsu_pkg::HELD;
				lsu_pkg::HELD: begin
					if (flush) state <= lsu_pkg::EMPTY;
					else if (launch) state <= lsu_pkg::WAIT;
				end
				// stay here until lsu has written back or the operation is dropped
				lsu_pkg::WAIT: if (flush | wb_valid) state <= lsu_pkg::EMPTY;
				default: state <= lsu_pkg::EMPTY;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) exeparam <= param_next;
	end

	a_cmd_not_busy: assert property (@(posedge CLK) disable iff (rst)
		cmd_valid |-> !cmd_busy);

	a_funct3_legal: assert property (@(posedge CLK) disable iff (rst)
		accept |-> funct3_legal);

endmodule

// ==== src/lsu_pkg.sv ====
// lsu_pkg holds the vector types and packed bundles shared by the load/store slice
`include "lsu_settings.svh"

package lsu_pkg;

	// ########################################
	// plain vectors
	// ########################################

	typedef logic [`LSU_XLEN-1:0] xlen_t;
	typedef logic [5+`LSU_RB-1:0] rd_tag_t;
	typedef logic [`LSU_XLEN/8-1:0] strb_t;
	typedef logic [2:0] funct3_t;
	typedef logic signed [11:0] imm12_t;

	// ########################################
	// bundles
	// ########################################

	// decoded memory command as it arrives at the top level
	// for stores the base field carries the rs2 value to be written
	typedef struct packed {
		logic    is_load;
		logic    is_store;
		logic    is_fence;
		logic    is_fence_i;
		funct3_t funct3;
		rd_tag_t rd;
		xlen_t   base;
		imm12_t  offset;
	} lsu_cmd_t;

	// execute parameter with one flag per operation followed by tag, address and store data
	typedef struct packed {
		logic    lb;
		logic    lh;
		logic    lw;
		logic    ld;
		logic    lbu;
		logic    lhu;
		logic    lwu;
		logic    sb;
		logic    sh;
		logic    sw;
		logic    sd;
		logic    fence_i;
		logic    fence;
		rd_tag_t rd;
		xlen_t   op1;
		xlen_t   op2;
	} lsu_exeparam_t;

	// request towards the data memory with data and strobes right-justified
	typedef struct packed {
		logic [`LSU_AW-1:0] addr;
		xlen_t              wdata;
		strb_t              wstrb;
		logic               wen;
	} mem_req_t;

	typedef struct packed {
		rd_tag_t rd;
		xlen_t   result;
	} wb_t;

	typedef enum logic [1:0] {
		EMPTY,
		HELD,
		WAIT
	} issue_state_t;

endpackage

// ==== src/lsu_slice_top.sv ====
// lsu_slice_top joins the issue buffer, lsu and data memory into the load/store slice
`timescale 1ns/100ps

module lsu_slice_top (
	input  logic              CLK,
	input  logic              rst,
	input  lsu_pkg::lsu_cmd_t cmd,
	input  logic              cmd_valid,
	output logic              cmd_busy,
	input  logic              flush,
	output logic              wb_valid,
	output lsu_pkg::wb_t      wb
);

	lsu_pkg::lsu_exeparam_t exeparam;
	logic                   exeparam_valid;
	logic                   exeparam_ready;
	logic                   mst_req_valid;
	logic                   mst_req_ready;
	lsu_pkg::mem_req_t      req;
	lsu_pkg::xlen_t         rdata;
	logic                   slv_rsp_valid;

	lsu_issue u_issue (
		.CLK            (CLK),
		.rst            (rst),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.cmd_busy       (cmd_busy),
		.flush          (flush),
		.exeparam_ready (exeparam_ready),
		.wb_valid       (wb_valid),
		.exeparam       (exeparam),
		.exeparam_valid (exeparam_valid)
	);

	lsu u_lsu (
		.CLK            (CLK),
		.rst            (rst),
		.exeparam       (exeparam),
		.exeparam_valid (exeparam_valid),
		.exeparam_ready (exeparam_ready),
		.mst_req_valid  (mst_req_valid),
		.mst_req_ready  (mst_req_ready),
		.req            (req),
		.rdata          (rdata),
		.slv_rsp_valid  (slv_rsp_valid),
		.flush          (flush),
		.wb_valid       (wb_valid),
		.wb             (wb)
	);

	lsu_dmem u_dmem (
		.CLK           (CLK),
		.rst           (rst),
		.mst_req_valid (mst_req_valid),
		.mst_req_ready (mst_req_ready),
		.req           (req),
		.slv_rsp_valid (slv_rsp_valid),
		.rdata         (rdata)
	);

endmodule
